// ==== Makefile ====
SRCS = $(shell cat filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dcache: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_dcache -f filelist.f

run: obj_dir/Vtb_dcache
	obj_dir/Vtb_dcache +verilator+error+limit+100 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import dcache_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  cache_req_if.ctrl_side req,
  mem_req_if.ctrl_side   mem
);

  cache_state_e        state_r;
  cache_state_e        state_n;
  logic [LINES-1:0]    valid_r;
  logic [LINES-1:0]    dirty_r;
  logic                line_valid_r;
  logic                line_dirty_r;
  line_entry_t         rd_entry;
  line_entry_t         wr_entry;
  logic                wr_en;
  logic [BYTES-1:0]    wr_mask;
  logic                rd_en;
  logic                tag_hit;
  logic                victim_dirty;
  logic                full_mask;
  logic [DATA_W-1:0]   fill_word;
  logic [DATA_W-1:0]   load_word_r;
  logic                start_r;
  logic                mem_we_r;
  logic [31:0]         mem_addr_r;
  logic [DATA_W-1:0]   mem_wdata_r;
  logic [CACHED_W-1:0] victim_off;
  logic [CACHED_W-1:0] fetch_off;

  assign rd_en        = (state_r == ST_IDLE) && req.req_valid;
  assign tag_hit      = line_valid_r && (rd_entry.tag == req.tag);
  assign victim_dirty = line_valid_r && line_dirty_r;
  assign full_mask    = &req.mask;
  assign victim_off   = {rd_entry.tag, req.index, 2'b00};
  assign fetch_off    = {req.full_addr[CACHED_W-1:INDEX_LSB], 2'b00};

  line_store i_line_store (
    .clk_i      (clk_i),
    .wr_en_i    (wr_en),
    .wr_index_i (req.index),
    .wr_mask_i  (wr_mask),
    .wr_entry_i (wr_entry),
    .rd_en_i    (rd_en),
    .rd_index_i (req.index),
    .rd_entry_o (rd_entry)
  );

  // Store bytes laid over the fetched word
  always_comb begin
    fill_word = mem.rdata;
    if (req.is_write) begin
      for (int b = 0; b < BYTES; b++) begin
        if (req.mask[b]) begin
          fill_word[8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (req.req_valid) begin
          state_n = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (tag_hit) begin
          state_n = req.is_write ? ST_STORE_WRITE : ST_DONE;
        end else if (victim_dirty) begin
          state_n = ST_MEM_WRITE;
        end else if (req.is_write && full_mask) begin
          state_n = ST_STORE_WRITE;
        end else begin
          state_n = ST_MEM_READ;
        end
      end
      ST_STORE_WRITE: state_n = ST_DONE;
      ST_MEM_WRITE: begin
        // Victim is out, carry on as a plain miss
        if (mem.ack) begin
          state_n = (req.is_write && full_mask) ? ST_STORE_WRITE : ST_MEM_READ;
        end
      end
      ST_MEM_READ: begin
        if (mem.ack) begin
          state_n = ST_DONE;
        end
      end
      ST_DONE: state_n = ST_IDLE;
      default: state_n = ST_IDLE;
    endcase
  end

  always_comb begin
    wr_en         = 1'b0;
    wr_mask       = req.mask;
    wr_entry.tag  = req.tag;
    wr_entry.data = req.wdata;
    if (state_r == ST_STORE_WRITE) begin
      wr_en = 1'b1;
    end else if (state_r == ST_MEM_READ && mem.ack) begin
      wr_en         = 1'b1;
      wr_mask       = '1;
      wr_entry.data = fill_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
      valid_r <= '0;
      dirty_r <= '0;
      start_r <= 1'b0;
    end else begin
      state_r <= state_n;
      start_r <= (state_n != state_r) &&
                 (state_n == ST_MEM_READ || state_n == ST_MEM_WRITE);
      // Fills from a load stay clean
      if (wr_en) begin
        valid_r[req.index] <= 1'b1;
        dirty_r[req.index] <= req.is_write;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE) begin
      line_valid_r <= valid_r[req.index];
      line_dirty_r <= dirty_r[req.index];
    end
    if (state_r == ST_LOOKUP && tag_hit) begin
      load_word_r <= rd_entry.data;
    end else if (state_r == ST_MEM_READ && mem.ack) begin
      load_word_r <= mem.rdata;
    end
    if (state_r == ST_LOOKUP && state_n == ST_MEM_WRITE) begin
      mem_addr_r  <= MEM_BASE + 32'(victim_off);
      mem_wdata_r <= rd_entry.data;
      mem_we_r    <= 1'b1;
    end else if (state_n == ST_MEM_READ && state_r != ST_MEM_READ) begin
      mem_addr_r <= MEM_BASE + 32'(fetch_off);
      mem_we_r   <= 1'b0;
    end
  end

  assign req.busy       = (state_n != ST_IDLE);
  assign req.rdata_load = load_word_r;

  assign mem.start    = start_r;
  assign mem.is_write = mem_we_r;
  assign mem.addr     = mem_addr_r;
  assign mem.wdata    = mem_wdata_r;

endmodule

// ==== cache_req_if.sv ====
`timescale 1ns/1ps

interface cache_req_if import dcache_pkg::*; ();
  logic               req_valid;
  logic               is_write;
  logic [TAG_W-1:0]   tag;
  logic [INDEX_W-1:0] index;
  logic [BYTES-1:0]   mask;
  logic [DATA_W-1:0]  wdata;
  logic [31:0]        full_addr;

  // Back from the controller
  logic               busy;
  logic [DATA_W-1:0]  rdata_load;

  modport cpu_side (
    output req_valid, is_write, tag, index, mask, wdata, full_addr,
    input  busy, rdata_load
  );

  modport ctrl_side (
    input  req_valid, is_write, tag, index, mask, wdata, full_addr,
    output busy, rdata_load
  );
endinterface

// ==== dcache_assertions.sv ====
`timescale 1ns/1ps

module dcache_assertions import dcache_pkg::*; (
  input logic        clk_i,
  input logic        rst_i,
  input logic [31:0] addr_i,
  input logic        stall_i,
  input logic        mem_valid_i,
  input logic        mem_we_i,
  input logic [31:0] mem_addr_i,
  input logic [31:0] mem_wdata_i,
  input logic        mem_ready_i
);

  int hold_fail   = 0;
  int reset_fail  = 0;
  int stall_fail  = 0;
  int victim_fail = 0;

  // Request frozen until the memory takes it
  a_req_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_we_i) &&
      $stable(mem_addr_i) && $stable(mem_wdata_i)
  ) else begin
    hold_fail++;
    $error("memory request changed before ready");
  end

  a_reset_idle: assert property (
    @(posedge clk_i) rst_i |=> !mem_valid_i
  ) else begin
    reset_fail++;
    $error("mem_valid_o high after a reset cycle");
  end

  a_valid_stalled: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_valid_i |-> stall_i
  ) else begin
    stall_fail++;
    $error("memory request while the load/store side is not stalled");
  end

  // Write-back only for a line of the same index but another tag
  a_victim_only: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_valid_i && mem_we_i |->
      (mem_addr_i[INDEX_LSB +: INDEX_W] == addr_i[INDEX_LSB +: INDEX_W]) &&
      (mem_addr_i[TAG_LSB +: TAG_W] != addr_i[TAG_LSB +: TAG_W])
  ) else begin
    victim_fail++;
    $error("memory write without an index conflict");
  end

endmodule

bind dcache_top dcache_assertions i_dcache_assertions (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .addr_i      (addr_i),
  .stall_i     (stall_o),
  .mem_valid_i (mem_valid_o),
  .mem_we_i    (mem_we_o),
  .mem_addr_i  (mem_addr_o),
  .mem_wdata_i (mem_wdata_o),
  .mem_ready_i (mem_ready_i)
);

// ==== dcache_golden.txt ====
// Fields op_rd_wr_addr_mask_data_expect in hex, rd and wr are memory reads and writes
// Op 1 is a load, 2 a store, 3 a check of the memory model
1_1_0_00000100_0_00000000_5b5ae5a5
1_0_0_00000100_0_00000000_5b5ae5a5
2_0_0_00000200_f_12345678_00000000
1_0_0_00000200_0_00000000_12345678
2_1_0_00000304_3_aabbccdd_00000000
1_0_0_00000304_0_00000000_595eccdd
2_1_0_00000308_c_11223344_00000000
1_0_0_00000308_0_00000000_1122e5a5
1_1_1_00000a00_0_00000000_505ae5a5
3_0_0_00000200_0_00000000_12345678
1_1_0_00000200_0_00000000_12345678
1_1_1_00000b04_0_00000000_515ee5a5
3_0_0_00000304_0_00000000_595eccdd
2_0_1_00000b08_f_cafef00d_00000000
3_0_0_00000308_0_00000000_1122e5a5
1_0_0_00000b08_0_00000000_cafef00d
1_1_0_00001100_0_00000000_4b5ae5a5
1_1_0_00000100_0_00000000_5b5ae5a5
3_0_0_00000100_0_00000000_5b5ae5a5
3_0_0_00001100_0_00000000_4b5ae5a5
2_1_0_00002200_1_000000ee_00000000
1_0_0_00002200_0_00000000_785ae5ee
1_1_1_00000200_0_00000000_12345678
3_0_0_00002200_0_00000000_785ae5ee
1_1_0_00007ffc_0_00000000_25a6e5a5
2_0_0_00007ffc_6_00abcd00_00000000
1_0_0_00007ffc_0_00000000_25abcda5
1_1_0_00000304_0_00000000_595eccdd
1_1_1_00000308_0_00000000_1122e5a5
3_0_0_00000b08_0_00000000_cafef00d

// ==== dcache_pkg.sv ====
package dcache_pkg;

  // Cache geometry
  localparam int DATA_W    = 32;
  localparam int BYTES     = DATA_W / 8;
  localparam int INDEX_W   = 9;
  localparam int TAG_W     = 8;
  localparam int LINES     = 512;

  // Address field positions
  localparam int INDEX_LSB = 2;
  localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
  localparam int CACHED_W  = TAG_LSB + TAG_W;

  // Main memory window holding the cached region
  localparam logic [31:0] MEM_BASE = 32'h4000_0000;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_STORE_WRITE,
    ST_MEM_READ,
    ST_MEM_WRITE,
    ST_DONE
  } cache_state_e;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } line_entry_t;

endpackage

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
  input  logic        clk_i,
  input  logic        rst_i,
  // Load/store unit
  input  logic        sel_i,
  input  logic        write_i,
  input  logic [3:0]  mask_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] load_data_o,
  output logic        stall_o,
  // Main memory controller
  output logic        mem_valid_o,
  output logic        mem_we_o,
  output logic [31:0] mem_addr_o,
  output logic [31:0] mem_wdata_o,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_ready_i
);

  cache_req_if req_bus ();
  mem_req_if   mem_bus ();

  lsu_port i_lsu_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sel_i       (sel_i),
    .write_i     (write_i),
    .mask_i      (mask_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .load_data_o (load_data_o),
    .stall_o     (stall_o),
    .req         (req_bus.cpu_side)
  );

  cache_ctrl i_cache_ctrl (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (req_bus.ctrl_side),
    .mem   (mem_bus.ctrl_side)
  );

  mem_port i_mem_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem         (mem_bus.bus_side),
    .mem_valid_o (mem_valid_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ready_i (mem_ready_i)
  );

endmodule

// ==== filelist.f ====
dcache_pkg.sv
cache_req_if.sv
mem_req_if.sv
lsu_port.sv
line_store.sv
cache_ctrl.sv
mem_port.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store import dcache_pkg::*; (
  input  logic               clk_i,
  input  logic               wr_en_i,
  input  logic [INDEX_W-1:0] wr_index_i,
  input  logic [BYTES-1:0]   wr_mask_i,
  input  line_entry_t        wr_entry_i,
  input  logic               rd_en_i,
  input  logic [INDEX_W-1:0] rd_index_i,
  output line_entry_t        rd_entry_o
);

  logic [TAG_W-1:0]  tag_mem  [LINES];
  logic [DATA_W-1:0] data_mem [LINES];

  // Tag is always written, data only on enabled bytes
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i] <= wr_entry_i.tag;
      for (int b = 0; b < BYTES; b++) begin
        if (wr_mask_i[b]) begin
          data_mem[wr_index_i][8*b +: 8] <= wr_entry_i.data[8*b +: 8];
        end
      end
    end
  end

  // Output holds between reads
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_entry_o.tag  <= tag_mem[rd_index_i];
      rd_entry_o.data <= data_mem[rd_index_i];
    end
  end

endmodule

// ==== lsu_port.sv ====
`timescale 1ns/1ps

module lsu_port import dcache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              sel_i,
  input  logic              write_i,
  input  logic [BYTES-1:0]  mask_i,
  input  logic [31:0]       addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] load_data_o,
  output logic              stall_o,
  cache_req_if.cpu_side     req
);

  logic              held_r;
  logic              done_r;
  logic              write_r;
  logic [BYTES-1:0]  mask_r;
  logic [31:0]       addr_r;
  logic [DATA_W-1:0] wdata_r;
  logic              capture;
  logic              finish;
  logic [31:0]       cur_addr;

  // done_r masks the old request still on the pins in the cycle after completion
  assign capture  = sel_i && !held_r && !done_r;
  assign finish   = held_r && !req.busy;
  assign cur_addr = held_r ? addr_r : addr_i;

  assign req.req_valid = held_r || capture;
  assign req.is_write  = held_r ? write_r : write_i;
  assign req.mask      = held_r ? mask_r : mask_i;
  assign req.wdata     = held_r ? wdata_r : wdata_i;
  assign req.full_addr = cur_addr;
  assign req.tag       = cur_addr[TAG_LSB +: TAG_W];
  assign req.index     = cur_addr[INDEX_LSB +: INDEX_W];

  assign stall_o = req.busy || held_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_r <= 1'b0;
      done_r <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (capture) begin
        held_r <= 1'b1;
      end else if (finish) begin
        held_r <= 1'b0;
        done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      write_r <= write_i;
      mask_r  <= mask_i;
      addr_r  <= addr_i;
      wdata_r <= wdata_i;
    end
    if (finish && !write_r) begin
      load_data_o <= req.rdata_load;
    end
  end

endmodule

// ==== mem_port.sv ====
`timescale 1ns/1ps

module mem_port import dcache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  mem_req_if.bus_side       mem,
  output logic              mem_valid_o,
  output logic              mem_we_o,
  output logic [31:0]       mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              mem_ready_i
);

  logic              valid_r;
  logic              ack_r;
  logic              we_r;
  logic [31:0]       addr_r;
  logic [DATA_W-1:0] wdata_r;
  logic [DATA_W-1:0] rdata_r;
  logic              accept;

  assign accept = valid_r && mem_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_r <= 1'b0;
      ack_r   <= 1'b0;
    end else begin
      ack_r <= 1'b0;
      if (mem.start) begin
        valid_r <= 1'b1;
      end else if (accept) begin
        valid_r <= 1'b0;
        ack_r   <= 1'b1;
      end
    end
  end

  // Request fields frozen from start until accepted
  always_ff @(posedge clk_i) begin
    if (mem.start) begin
      we_r    <= mem.is_write;
      addr_r  <= mem.addr;
      wdata_r <= mem.wdata;
    end
    if (accept) begin
      rdata_r <= mem_rdata_i;
    end
  end

  assign mem_valid_o = valid_r;
  assign mem_we_o    = we_r;
  assign mem_addr_o  = addr_r;
  assign mem_wdata_o = wdata_r;

  assign mem.ack   = ack_r;
  assign mem.rdata = rdata_r;

endmodule

// ==== mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if import dcache_pkg::*; ();
  logic              start;
  logic              is_write;
  logic [31:0]       addr;
  logic [DATA_W-1:0] wdata;
  logic              ack;
  logic [DATA_W-1:0] rdata;

  modport ctrl_side (
    output start, is_write, addr, wdata,
    input  ack, rdata
  );

  modport bus_side (
    input  start, is_write, addr, wdata,
    output ack, rdata
  );
endinterface

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam int STALL_TIMEOUT = 200;
  localparam int GOLDEN_DEPTH  = 64;

  logic        clk_i;
  logic        rst_i;
  logic        sel_i;
  logic        write_i;
  logic [3:0]  mask_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [31:0] load_data_o;
  logic        stall_o;
  logic        mem_valid_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic [31:0] mem_rdata_i;
  logic        mem_ready_i;

  // One golden line per entry, fields op rd wr addr mask data expect
  logic [111:0] golden_mem [GOLDEN_DEPTH];
  logic [31:0]  model_words [logic [31:0]];
  int           rd_total;
  int           wr_total;

  dcache_top i_dcache_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sel_i       (sel_i),
    .write_i     (write_i),
    .mask_i      (mask_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .load_data_o (load_data_o),
    .stall_o     (stall_o),
    .mem_valid_o (mem_valid_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ready_i (mem_ready_i)
  );

  // Memory contents before any write
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    if (model_words.exists(a)) begin
      return model_words[a];
    end
    return init_word(a);
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Cached offset placed in the memory window
  function automatic logic [31:0] mem_addr_of(input logic [31:0] a);
    return MEM_BASE + {13'd0, a[18:2], 2'b00};
  endfunction

  function automatic string op_name(input logic [3:0] op);
    case (op)
      4'd1:    return "load";
      4'd2:    return "store";
      default: return "memcheck";
    endcase
  endfunction

  task automatic wait_stall_low(output logic done);
    int cycles;
    cycles = 0;
    done   = 1'b0;
    while (cycles < STALL_TIMEOUT && !done) begin
      @(negedge clk_i);
      if (!stall_o) begin
        done = 1'b1;
      end
      cycles++;
    end
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // Main memory controller with random response delay
  initial begin : memory_model
    logic        pending;
    int          delay_left;
    logic [31:0] rng;
    logic [31:0] word_addr;
    mem_ready_i = 1'b0;
    mem_rdata_i = '0;
    rd_total    = 0;
    wr_total    = 0;
    pending     = 1'b0;
    delay_left  = 0;
    rng         = 32'd92238;
    forever begin
      @(negedge clk_i);
      if (mem_ready_i) begin
        mem_ready_i = 1'b0;
        pending     = 1'b0;
      end else if (mem_valid_o) begin
        if (!pending) begin
          pending    = 1'b1;
          rng        = lcg_next(rng);
          delay_left = int'((rng >> 16) % 32'd6);
        end
        if (delay_left == 0) begin
          word_addr = {mem_addr_o[31:2], 2'b00};
          if (mem_we_o) begin
            model_words[word_addr] = mem_wdata_o;
            wr_total++;
          end else begin
            mem_rdata_i = model_read(word_addr);
            rd_total++;
          end
          mem_ready_i = 1'b1;
        end else begin
          delay_left--;
        end
      end
    end
  end

  initial begin : stimulus
    logic [111:0] entry;
    logic [3:0]   op;
    logic [31:0]  addr;
    logic [31:0]  exp_word;
    logic [31:0]  got;
    logic         done;
    logic         test_ok;
    logic         timed_out;
    int           rd_before;
    int           wr_before;
    int           idx;
    int           tests;
    int           failed;
    int           assert_fails;
    sel_i     = 1'b0;
    write_i   = 1'b0;
    mask_i    = '0;
    addr_i    = '0;
    wdata_i   = '0;
    rst_i     = 1'b1;
    timed_out = 1'b0;
    tests     = 0;
    failed    = 0;
    idx       = 0;
    for (int i = 0; i < GOLDEN_DEPTH; i++) begin
      golden_mem[i] = '0;
    end
    $readmemh("dcache_golden.txt", golden_mem);
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    test_ok = 1'b1;
    if (stall_o !== 1'b0 || mem_valid_o !== 1'b0) begin
      $display("mismatch at %0t: stall_o or mem_valid_o high after reset", $time);
      test_ok = 1'b0;
    end
    tests++;
    if (!test_ok) begin
      failed++;
    end
    $display("test 0 reset %s", test_ok ? "ok" : "failed");

    while (idx < GOLDEN_DEPTH && golden_mem[idx][111:108] != 4'd0 && !timed_out) begin
      entry    = golden_mem[idx];
      op       = entry[111:108];
      addr     = entry[99:68];
      exp_word = entry[31:0];
      test_ok  = 1'b1;
      if (op == 4'd3) begin
        got = model_read(mem_addr_of(addr));
        if (got !== exp_word) begin
          $display("mismatch at %0t: memory at 0x%08h holds 0x%08h, expected 0x%08h",
                   $time, mem_addr_of(addr), got, exp_word);
          test_ok = 1'b0;
        end
      end else begin
        @(negedge clk_i);
        rd_before = rd_total;
        wr_before = wr_total;
        sel_i     = 1'b1;
        write_i   = (op == 4'd2);
        mask_i    = entry[67:64];
        addr_i    = addr;
        wdata_i   = entry[63:32];
        wait_stall_low(done);
        sel_i = 1'b0;
        if (!done) begin
          $display("test %0d never finished, stall_o stayed high", idx + 1);
          timed_out = 1'b1;
          test_ok   = 1'b0;
        end else begin
          if (op == 4'd1 && load_data_o !== exp_word) begin
            $display("mismatch at %0t: load 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, addr, load_data_o, exp_word);
            test_ok = 1'b0;
          end
          if (rd_total - rd_before != int'(entry[107:104]) ||
              wr_total - wr_before != int'(entry[103:100])) begin
            $display("mismatch at %0t: saw %0d reads and %0d writes, expected %0d and %0d",
                     $time, rd_total - rd_before, wr_total - wr_before,
                     entry[107:104], entry[103:100]);
            test_ok = 1'b0;
          end
        end
      end
      tests++;
      if (!test_ok) begin
        failed++;
      end
      $display("test %0d %s 0x%08h %s", idx + 1, op_name(op), addr,
               test_ok ? "ok" : "failed");
      idx++;
    end

    if (idx == 0) begin
      $display("no operations were read from dcache_golden.txt");
      failed++;
    end
    assert_fails = i_dcache_top.i_dcache_assertions.hold_fail +
                   i_dcache_top.i_dcache_assertions.reset_fail +
                   i_dcache_top.i_dcache_assertions.stall_fail +
                   i_dcache_top.i_dcache_assertions.victim_fail;
    $display("tests %0d, failed %0d, assertion failures %0d", tests, failed, assert_fails);
    if (failed == 0 && assert_fails == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
